/* hdl/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// integer data path width.
`define LSU_XLEN 64

// data memory depth as a doubleword index width, 256 doublewords.
`define LSU_DMEM_AW 8

// cycles from req high to ack high, 1 or more.
`define LSU_DMEM_LAT 2

`endif

/* hdl/lsu_pkg.sv */
`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]    xlen_t;
    typedef logic [31:0]             inst_t;
    typedef logic [4:0]              reg_addr_t;
    typedef logic [3:0]              st_wdth_t;
    typedef logic [5:0]              ld_wdth_t;
    typedef logic [7:0]              byte_en_t;
    typedef logic [`LSU_DMEM_AW-1:0] dmem_addr_t;

    // bit positions inside st_wdth_t.
    localparam int ST_B = 0;
    localparam int ST_H = 1;
    localparam int ST_W = 2;
    localparam int ST_D = 3;

    // bit positions inside ld_wdth_t.
    localparam int LD_B  = 0;
    localparam int LD_H  = 1;
    localparam int LD_W  = 2;
    localparam int LD_D  = 3;
    localparam int LD_BU = 4;
    localparam int LD_HU = 5;

    typedef enum logic [1:0] {
        WB_EXU  = 2'd0,
        WB_CSR  = 2'd1,
        WB_LOAD = 2'd2
    } wb_sel_e;

    typedef enum logic [1:0] {
        MS_IDLE    = 2'd0,
        MS_REQ     = 2'd1,
        MS_RELEASE = 2'd2
    } mem_state_e;

    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        xlen_t     result;     // alu result, or the address for loads and stores.
        xlen_t     exu_wdata;
        xlen_t     csr_wdata;  // old csr value.
        logic      ram_we;
        xlen_t     ram_wdata;
        st_wdth_t  st_wdth;
        logic      ram_re;
        ld_wdth_t  ld_wdth;
        logic      reg_we;
        reg_addr_t reg_waddr;
        wb_sel_e   wb_sel;
    } ex_mem_t;

    typedef struct packed {
        xlen_t     pc;
        inst_t     inst;
        logic      reg_we;
        reg_addr_t reg_waddr;
        xlen_t     reg_wdata;
    } mem_wb_t;

endpackage

/* hdl/ex_mem_reg.sv */
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_i,
    input  lsu_pkg::ex_mem_t data_i,
    input  logic             stall_i,
    output logic             valid_o,
    output lsu_pkg::ex_mem_t data_o
);

    // pc and inst ride along for the commit trace only.
    always_ff @(posedge clk) begin
        if (rst_n) begin
            valid_o        <= 1'b0;
            // a bubble after reset must not touch memory or the register file.
            data_o.ram_we  <= 1'b0;
            data_o.ram_re  <= 1'b0;
            data_o.reg_we  <= 1'b0;
            data_o.st_wdth <= '0;
            data_o.ld_wdth <= '0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  lsu_pkg::ex_mem_t    data_i,
    output logic                stall_o,
    output logic                dmem_req_o,
    output logic                dmem_we_o,
    output lsu_pkg::dmem_addr_t dmem_addr_o,
    output lsu_pkg::byte_en_t   dmem_be_o,
    output lsu_pkg::xlen_t      dmem_wdata_o,
    input  logic                dmem_ack_i,
    input  lsu_pkg::xlen_t      dmem_rdata_i,
    output logic                valid_o,
    output lsu_pkg::mem_wb_t    data_o
);
    import lsu_pkg::*;

    mem_state_e state_q;
    mem_state_e state_d;
    logic       is_mem;
    logic       done;
    logic [2:0] offset;
    xlen_t      ld_shift;
    xlen_t      ld_value;
    xlen_t      wb_value;

    assign is_mem = data_i.ram_we | data_i.ram_re;
    assign offset = data_i.result[2:0];   // byte lane within the doubleword.
    assign done   = (state_q == MS_REQ) & dmem_ack_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MS_IDLE: begin
                if (valid_i && is_mem) begin
                    state_d = MS_REQ;
                end
            end
            MS_REQ: begin
                if (dmem_ack_i) begin
                    state_d = MS_RELEASE;
                end
            end
            MS_RELEASE: begin
                // wait for the memory to drop ack before the next request.
                if (!dmem_ack_i) begin
                    state_d = MS_IDLE;
                end
            end
            default: state_d = MS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= MS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request fields come straight from the held ex/mem register.
    assign dmem_req_o  = (state_q == MS_REQ);
    assign dmem_we_o   = data_i.ram_we;
    assign dmem_addr_o = data_i.result[$bits(dmem_addr_t)+2:3];

    always_comb begin
        dmem_wdata_o = data_i.ram_wdata;
        dmem_be_o    = '0;
        if (data_i.st_wdth[ST_B]) begin
            dmem_wdata_o = {8{data_i.ram_wdata[7:0]}};
            dmem_be_o    = 8'h01 << offset;
        end else if (data_i.st_wdth[ST_H]) begin
            dmem_wdata_o = {4{data_i.ram_wdata[15:0]}};
            dmem_be_o    = 8'h03 << offset;
        end else if (data_i.st_wdth[ST_W]) begin
            dmem_wdata_o = {2{data_i.ram_wdata[31:0]}};
            dmem_be_o    = 8'h0f << offset;
        end else if (data_i.st_wdth[ST_D]) begin
            dmem_be_o = 8'hff;
        end
    end

    assign ld_shift = dmem_rdata_i >> {offset, 3'b000};

    always_comb begin
        case (1'b1)
            data_i.ld_wdth[LD_B]:  ld_value = {{56{ld_shift[7]}}, ld_shift[7:0]};
            data_i.ld_wdth[LD_H]:  ld_value = {{48{ld_shift[15]}}, ld_shift[15:0]};
            data_i.ld_wdth[LD_W]:  ld_value = {{32{ld_shift[31]}}, ld_shift[31:0]};
            data_i.ld_wdth[LD_D]:  ld_value = ld_shift;
            data_i.ld_wdth[LD_BU]: ld_value = {56'b0, ld_shift[7:0]};
            data_i.ld_wdth[LD_HU]: ld_value = {48'b0, ld_shift[15:0]};
            default:               ld_value = ld_shift;
        endcase
    end

    always_comb begin
        case (data_i.wb_sel)
            WB_CSR:  wb_value = data_i.csr_wdata;
            WB_LOAD: wb_value = ld_value;
            default: wb_value = data_i.exu_wdata;
        endcase
    end

    // memory items hold the pipe until the ack cycle.
    assign stall_o = valid_i & is_mem & ~done;
    assign valid_o = valid_i & (~is_mem | done);

    assign data_o.pc        = data_i.pc;
    assign data_o.inst      = data_i.inst;
    assign data_o.reg_we    = data_i.reg_we;
    assign data_o.reg_waddr = data_i.reg_waddr;
    assign data_o.reg_wdata = wb_value;

endmodule

/* hdl/data_mem.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module data_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_i,
    input  logic                we_i,
    input  lsu_pkg::dmem_addr_t addr_i,
    input  lsu_pkg::byte_en_t   be_i,
    input  lsu_pkg::xlen_t      wdata_i,
    output logic                ack_o,
    output lsu_pkg::xlen_t      rdata_o
);
    import lsu_pkg::*;

    localparam int DEPTH = 1 << `LSU_DMEM_AW;
    localparam int CNT_W = $clog2(`LSU_DMEM_LAT + 1);

    xlen_t            mem [DEPTH];
    logic [CNT_W-1:0] wait_cnt;
    logic             fire;

    // last cycle of the delay, the access happens on this edge.
    assign fire = req_i & ~ack_o & (wait_cnt == CNT_W'(`LSU_DMEM_LAT - 1));

    always_ff @(posedge clk) begin
        if (rst_n) begin
            ack_o    <= 1'b0;
            wait_cnt <= '0;
        end else if (ack_o) begin
            wait_cnt <= '0;
            if (!req_i) begin
                ack_o <= 1'b0;   // four-phase release.
            end
        end else if (fire) begin
            ack_o    <= 1'b1;
            wait_cnt <= '0;
        end else if (req_i) begin
            wait_cnt <= wait_cnt + CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            rdata_o <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (fire) begin
            rdata_o <= mem[addr_i];
            for (int b = 0; b < 8; b++) begin
                if (we_i && be_i[b]) begin
                    mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* hdl/wb_stage.sv */
`timescale 1ns/100ps

module wb_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               valid_i,
    input  lsu_pkg::mem_wb_t   data_i,
    input  lsu_pkg::reg_addr_t rf_raddr_i,
    output lsu_pkg::xlen_t     rf_rdata_o,
    output logic               commit_valid_o,
    output lsu_pkg::mem_wb_t   commit_o
);
    import lsu_pkg::*;

    xlen_t rf [32];
    logic  rf_we;

    assign rf_we = valid_i & data_i.reg_we & (data_i.reg_waddr != '0);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= valid_i;   // one pulse per retired item.
        end
    end

    // trace payload, only meaningful with commit_valid_o.
    always_ff @(posedge clk) begin
        if (valid_i) begin
            commit_o <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[data_i.reg_waddr] <= data_i.reg_wdata;
        end
    end

    // x0 always reads zero.
    assign rf_rdata_o = (rf_raddr_i == '0) ? '0 : rf[rf_raddr_i];

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/100ps

module lsu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ex_valid_i,
    input  lsu_pkg::ex_mem_t   ex_i,
    output logic               ex_ready_o,
    input  lsu_pkg::reg_addr_t rf_raddr_i,
    output lsu_pkg::xlen_t     rf_rdata_o,
    output logic               commit_valid_o,
    output lsu_pkg::mem_wb_t   commit_o
);
    import lsu_pkg::*;

    logic       em_valid;
    ex_mem_t    em;
    logic       mem_stall;
    logic       mw_valid;
    mem_wb_t    mw;
    logic       dmem_req;
    logic       dmem_we;
    dmem_addr_t dmem_addr;
    byte_en_t   dmem_be;
    xlen_t      dmem_wdata;
    logic       dmem_ack;
    xlen_t      dmem_rdata;

    assign ex_ready_o = ~mem_stall;   // memory wait is the only back-pressure.

    ex_mem_reg i_ex_mem_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (ex_valid_i),
        .data_i  (ex_i),
        .stall_i (mem_stall),
        .valid_o (em_valid),
        .data_o  (em)
    );

    mem_stage i_mem_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (em_valid),
        .data_i       (em),
        .stall_o      (mem_stall),
        .dmem_req_o   (dmem_req),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_be_o    (dmem_be),
        .dmem_wdata_o (dmem_wdata),
        .dmem_ack_i   (dmem_ack),
        .dmem_rdata_i (dmem_rdata),
        .valid_o      (mw_valid),
        .data_o       (mw)
    );

    data_mem i_data_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (dmem_req),
        .we_i    (dmem_we),
        .addr_i  (dmem_addr),
        .be_i    (dmem_be),
        .wdata_i (dmem_wdata),
        .ack_o   (dmem_ack),
        .rdata_o (dmem_rdata)
    );

    wb_stage i_wb_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (mw_valid),
        .data_i         (mw),
        .rf_raddr_i     (rf_raddr_i),
        .rf_rdata_o     (rf_rdata_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

/* sim/lsu_properties.sv */
`timescale 1ns/100ps

module lsu_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                req_i,
    input logic                ack_i,
    input lsu_pkg::dmem_addr_t addr_i,
    input logic                ex_ready_i
);

    // four-phase port, req holds until ack.
    req_held: assert property (@(posedge clk) disable iff (rst_n)
        req_i && !ack_i |=> req_i)
        else $error("dmem req dropped before ack");

    ack_needs_req: assert property (@(posedge clk) disable iff (rst_n)
        $rose(ack_i) |-> $past(req_i))
        else $error("dmem ack rose without a request");

    addr_stable: assert property (@(posedge clk) disable iff (rst_n)
        req_i && !ack_i |=> $stable(addr_i))
        else $error("dmem address changed during a request");

    ready_after_reset: assert property (@(posedge clk)
        $fell(rst_n) |-> ex_ready_i)
        else $error("ex_ready_o low right after reset");

endmodule

bind lsu_top lsu_properties i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (dmem_req),
    .ack_i      (dmem_ack),
    .addr_i     (dmem_addr),
    .ex_ready_i (ex_ready_o)
);

/* sim/lsu_tb.sv */
`timescale 1ns/100ps
`include "lsu_settings.svh"

module lsu_tb;
    import lsu_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      ex_valid_i;
    ex_mem_t   ex_i;
    logic      ex_ready_o;
    reg_addr_t rf_raddr_i;
    xlen_t     rf_rdata_o;
    logic      commit_valid_o;
    mem_wb_t   commit_o;

    logic [15:0] lfsr_q = 16'd24811;
    logic [63:0] pc_q = 64'h8000_0000;
    logic [63:0] model_mem [1 << `LSU_DMEM_AW];
    logic [63:0] model_rf [32];
    ex_mem_t     items [$];
    mem_wb_t     exp_q [$];
    int          acc_cyc_q [$];
    bit          mem_q [$];
    int          cycle = 0;
    int          limit = 1000;

    lsu_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_valid_i     (ex_valid_i),
        .ex_i           (ex_i),
        .ex_ready_o     (ex_ready_o),
        .rf_raddr_i     (rf_raddr_i),
        .rf_rdata_o     (rf_rdata_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_step();
        end
        return v;
    endfunction

    function automatic ex_mem_t base_item();
        ex_mem_t it;
        it = '0;
        it.pc = pc_q;
        pc_q = pc_q + 64'd4;
        it.inst = 32'(rand_bits(32));
        it.exu_wdata = rand_bits(64);
        it.csr_wdata = rand_bits(64);
        it.wb_sel = WB_EXU;
        return it;
    endfunction

    function automatic ex_mem_t alu_item(input wb_sel_e sel, input reg_addr_t rd);
        ex_mem_t it;
        it = base_item();
        it.result = rand_bits(64);
        it.wb_sel = sel;
        it.reg_we = 1'b1;
        it.reg_waddr = rd;
        return it;
    endfunction

    // offset is naturally aligned to the access size.
    function automatic logic [63:0] mem_addr(input dmem_addr_t idx, input int size);
        logic [2:0] off;
        off = 3'(rand_bits(3)) & ~3'(size - 1);
        return 64'({idx, off});
    endfunction

    function automatic ex_mem_t store_item(input int w, input dmem_addr_t idx);
        ex_mem_t it;
        it = base_item();
        it.result = mem_addr(idx, 1 << w);
        it.ram_we = 1'b1;
        it.st_wdth = 4'(1 << w);
        it.ram_wdata = rand_bits(64);
        return it;
    endfunction

    function automatic ex_mem_t load_item(input int k, input dmem_addr_t idx, input reg_addr_t rd);
        ex_mem_t it;
        int      sizes [6] = '{1, 2, 4, 8, 1, 2};
        it = base_item();
        it.result = mem_addr(idx, sizes[k]);
        it.ram_re = 1'b1;
        it.ld_wdth = 6'(1 << k);
        it.wb_sel = WB_LOAD;
        it.reg_we = 1'b1;
        it.reg_waddr = rd;
        return it;
    endfunction

    // reference model of memory and register file, called once per accepted item.
    function automatic mem_wb_t predict(input ex_mem_t it);
        mem_wb_t     r;
        logic [63:0] word;
        logic [63:0] ld;
        int          idx;
        int          off;
        int          n;
        bit          sign;
        idx = int'(it.result[`LSU_DMEM_AW+2:3]);
        off = int'(it.result[2:0]);
        ld = '0;
        if (it.ram_we) begin
            n = it.st_wdth[0] ? 1 : it.st_wdth[1] ? 2 : it.st_wdth[2] ? 4 : 8;
            for (int b = 0; b < n; b++) begin
                model_mem[idx][(off+b)*8 +: 8] = it.ram_wdata[b*8 +: 8];
            end
        end
        if (it.ram_re) begin
            n = (it.ld_wdth[0] || it.ld_wdth[4]) ? 1 :
                (it.ld_wdth[1] || it.ld_wdth[5]) ? 2 : it.ld_wdth[2] ? 4 : 8;
            sign = it.ld_wdth[0] | it.ld_wdth[1] | it.ld_wdth[2];
            word = model_mem[idx];
            for (int b = 0; b < n; b++) begin
                ld[b*8 +: 8] = word[(off+b)*8 +: 8];
            end
            if (sign && n < 8 && ld[n*8-1]) begin
                for (int b = n; b < 8; b++) begin
                    ld[b*8 +: 8] = 8'hff;
                end
            end
        end
        r.pc = it.pc;
        r.inst = it.inst;
        r.reg_we = it.reg_we;
        r.reg_waddr = it.reg_waddr;
        case (it.wb_sel)
            WB_CSR:  r.reg_wdata = it.csr_wdata;
            WB_LOAD: r.reg_wdata = ld;
            default: r.reg_wdata = it.exu_wdata;
        endcase
        if (r.reg_we && r.reg_waddr != '0) begin
            model_rf[r.reg_waddr] = r.reg_wdata;
        end
        return r;
    endfunction

    task automatic build_items();
        dmem_addr_t idx;
        for (int i = 0; i < 11; i++) begin
            items.push_back(alu_item(rand_bits(1) ? WB_CSR : WB_EXU, 5'(rand_bits(5))));
        end
        items.push_back(alu_item(WB_EXU, 5'd0));   // x0 must stay zero.
        for (int w = 0; w < 4; w++) begin
            for (int j = 0; j < 2; j++) begin
                idx = dmem_addr_t'(rand_bits(`LSU_DMEM_AW));
                items.push_back(store_item(w, idx));
                items.push_back(load_item(3, idx, 5'(rand_bits(5))));
            end
        end
        for (int k = 0; k < 6; k++) begin
            for (int j = 0; j < 2; j++) begin
                idx = dmem_addr_t'(rand_bits(`LSU_DMEM_AW));
                items.push_back(store_item(3, idx));
                items.push_back(load_item(k, idx, 5'(rand_bits(5))));
            end
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            stop_run();
        end
    end

    always @(posedge clk) begin
        mem_wb_t exp;
        int      acc;
        bit      is_mem;
        if (!rst_n && commit_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("a commit appeared without a matching accepted item");
                stop_run();
            end else begin
                exp = exp_q.pop_front();
                acc = acc_cyc_q.pop_front();
                is_mem = mem_q.pop_front();
                check("commit_o.pc", commit_o.pc, exp.pc);
                check("commit_o.inst", 64'(commit_o.inst), 64'(exp.inst));
                check("commit_o.reg_we", 64'(commit_o.reg_we), 64'(exp.reg_we));
                check("commit_o.reg_waddr", 64'(commit_o.reg_waddr), 64'(exp.reg_waddr));
                check("commit_o.reg_wdata", commit_o.reg_wdata, exp.reg_wdata);
                if (!is_mem) begin
                    check("commit latency", 64'(cycle - acc), 64'd2);
                end
            end
        end
    end

    initial begin
        int gap;
        rst_n = 1'b1;
        ex_valid_i = 1'b0;
        ex_i = '0;
        rf_raddr_i = 5'd7;
        for (int i = 0; i < (1 << `LSU_DMEM_AW); i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        build_items();
        limit = items.size() * (2 * `LSU_DMEM_LAT + 6) + 50;

        repeat (3) @(posedge clk);
        rst_n <= 1'b0;
        @(negedge clk);
        check("commit_valid_o", 64'(commit_valid_o), 64'd0);
        check("ex_ready_o", 64'(ex_ready_o), 64'd1);
        check("rf_rdata_o", rf_rdata_o, 64'd0);
        @(posedge clk);

        foreach (items[i]) begin
            gap = int'(rand_bits(2));
            if (gap > 0) begin
                ex_valid_i <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            ex_valid_i <= 1'b1;
            ex_i <= items[i];
            do begin
                @(posedge clk);
            end while (!ex_ready_o);   // transfer happens on this edge.
            exp_q.push_back(predict(items[i]));
            acc_cyc_q.push_back(cycle);
            mem_q.push_back(items[i].ram_we | items[i].ram_re);
        end
        ex_valid_i <= 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        for (int r = 0; r < 32; r++) begin
            rf_raddr_i <= 5'(r);
            @(negedge clk);
            check("rf_rdata_o", rf_rdata_o, model_rf[r]);
            @(posedge clk);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/lsu_pkg.sv
hdl/ex_mem_reg.sv
hdl/mem_stage.sv
hdl/data_mem.sv
hdl/wb_stage.sv
hdl/lsu_top.sv
sim/lsu_properties.sv
sim/lsu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module lsu_tb -Mdir obj_dir

output=$(./obj_dir/Vlsu_tb)
echo "$output"
echo "$output" | grep -q "^TB PASSED$"
